/* sim.f */
+incdir+testbench
verilog/mipsPkg.sv
verilog/pipeIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
testbench/tbMips.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbMips -f sim.f -o tbMips

# The simulator exits nonzero on $fatal, the pass line decides the result
output=$(./obj_dir/tbMips || true)
echo "$output"

if echo "$output" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1

/* testbench/tbMipsModel.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

////////////////////////////////////////
// Program store and reference model
////////////////////////////////////////
wordT    progMem [IMEM_DEPTH];                      // Image written through the imem port
wordT    modelRegs [32];
wordT    modelMem [DMEM_DEPTH];
regAddrT expWbReg [$];                              // Expected register writes, in order
wordT    expWbData [$];
wordT    expStAddr [$];                             // Expected stores, in order
wordT    expStData [$];

function automatic regAddrT randReg();
	return regAddrT'($urandom % 8);                 // r0..r7 keeps hazards frequent
endfunction

function automatic wordT encodeR(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
	return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic wordT encodeI(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic int memIndex(wordT addr);
	return int'((addr >> 2) % DMEM_DEPTH);          // Word address, wraps at depth
endfunction

task automatic genProgram();
	int          kind;
	int          off;
	int          span;
	regAddrT     rs;
	regAddrT     rt;
	regAddrT     rd;
	logic [15:0] immS;
	logic [15:0] immU;
	logic [15:0] memOff;
	for (int i = 0; i < IMEM_DEPTH; i++) begin
		progMem[i] = NOP_WORD;                      // Padding behind the program
	end
	for (int i = 0; i < PROG_LEN; i++) begin
		rs     = randReg();
		rt     = randReg();
		rd     = randReg();
		immS   = 16'($urandom % 64) - 16'd32;       // Small signed constant
		immU   = 16'($urandom % 32768);             // Bit 15 clear, same under either extension
		memOff = 16'(($urandom % MEM_SPAN) * 4);    // Few words, so loads hit earlier stores
		span   = (PROG_LEN - i < 4) ? (PROG_LEN - i) : 4;
		off    = $urandom % span;                   // Forward, target at most PROG_LEN
		kind   = $urandom % 12;
		case (kind)
			0:       progMem[i] = encodeR(FN_ADD, rd, rs, rt);
			1:       progMem[i] = encodeR(FN_SUB, rd, rs, rt);
			2:       progMem[i] = encodeR(FN_AND, rd, rs, rt);
			3:       progMem[i] = encodeR(FN_OR, rd, rs, rt);
			4:       progMem[i] = encodeR(FN_SLT, rd, rs, rt);
			5:       progMem[i] = encodeI(OP_ADDI, rt, rs, immS);
			6:       progMem[i] = encodeI(OP_ANDI, rt, rs, immU);
			7:       progMem[i] = encodeI(OP_ORI, rt, rs, immU);
			8:       progMem[i] = encodeI(OP_LW, rt, 5'd0, memOff);  // Base is always r0
			9:       progMem[i] = encodeI(OP_SW, rt, 5'd0, memOff);
			10:      progMem[i] = encodeI(OP_BEQ, rt, rs, 16'(off));
			default: progMem[i] = encodeI(OP_BNE, rt, rs, 16'(off));
		endcase
	end
endtask

task automatic modelWrite(regAddrT r, wordT value);
	if (r != '0) begin                              // r0 stays zero and is never reported
		modelRegs[r] = value;
		expWbReg.push_back(r);
		expWbData.push_back(value);
	end
endtask

// In-order ISA execution, no delay slot
task automatic runModel();
	int      pc;
	int      nextPc;
	wordT    ins;
	wordT    immExt;
	wordT    a;
	wordT    b;
	opcodeT  op;
	functT   fn;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	expWbReg.delete();
	expWbData.delete();
	expStAddr.delete();
	expStData.delete();
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	for (int i = 0; i < DMEM_DEPTH; i++) begin
		modelMem[i] = '0;
	end
	pc = 0;
	while (pc < PROG_LEN) begin
		ins    = progMem[pc];
		op     = opcodeT'(ins[31:26]);
		fn     = functT'(ins[5:0]);
		rs     = ins[25:21];
		rt     = ins[20:16];
		rd     = ins[15:11];
		immExt = {{16{ins[15]}}, ins[15:0]};
		a      = modelRegs[rs];
		b      = modelRegs[rt];
		nextPc = pc + 1;
		case (op)
			OP_RTYPE: begin
				case (fn)
					FN_ADD:  modelWrite(rd, a + b);
					FN_SUB:  modelWrite(rd, a - b);
					FN_AND:  modelWrite(rd, a & b);
					FN_OR:   modelWrite(rd, a | b);
					FN_SLT:  modelWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
			end
			OP_ADDI: modelWrite(rt, a + immExt);
			OP_ANDI: modelWrite(rt, a & immExt);
			OP_ORI:  modelWrite(rt, a | immExt);
			OP_LW:   modelWrite(rt, modelMem[memIndex(a + immExt)]);
			OP_SW: begin
				expStAddr.push_back(a + immExt);
				expStData.push_back(b);
				modelMem[memIndex(a + immExt)] = b;
			end
			OP_BEQ: if (a == b) nextPc = pc + 1 + int'(immExt);   // Offset from PC+4 in words
			OP_BNE: if (a != b) nextPc = pc + 1 + int'(immExt);
			default: ;
		endcase
		pc = nextPc;
	end
endtask

`endif

/* testbench/tbMips.sv */
module tbMips;
	import mipsPkg::*;

	localparam int IMEM_DEPTH    = 64;
	localparam int DMEM_DEPTH    = 64;
	localparam int IMEM_AW       = $clog2(IMEM_DEPTH);
	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 3;
	localparam int NUM_PROGRAMS  = 20;
	localparam int PROG_LEN      = 40;
	localparam int MEM_SPAN      = 8;                   // Data words touched by lw and sw
	localparam int DRAIN_CYCLES  = 8;                   // Quiet time that catches extra events
	localparam int WATCHDOG_TIME = NUM_PROGRAMS * PROG_LEN * 8 * CLK_PERIOD;
	localparam int SEED          = 32'h51d1be94;

	logic               clk;
	logic               rst;
	logic               imemWrEn;
	logic [IMEM_AW-1:0] imemAddr;
	wordT               imemData;
	logic               wbValid;
	regAddrT            wbReg;
	wordT               wbData;
	logic               memWrEn;
	wordT               memAddr;
	wordT               memData;
	logic               checking;                   // Monitors armed after the first reset

	`include "tbMipsModel.svh"

	mipsCore #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) UUT (
		.clk(clk), .rst_i(rst), .imemWrEn_i(imemWrEn), .imemAddr_i(imemAddr),
		.imemData_i(imemData), .wbValid_o(wbValid), .wbReg_o(wbReg), .wbData_o(wbData),
		.memWrEn_o(memWrEn), .memAddr_o(memAddr), .memData_o(memData)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic failRun(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkWriteback(regAddrT gotReg, wordT gotData, regAddrT expReg,
		wordT expData);
		if (gotReg !== expReg || gotData !== expData) begin
			failRun($sformatf("** Error at %0t: writeback r%0d = %08h, expected r%0d = %08h",
				$time, gotReg, gotData, expReg, expData));
		end
	endtask

	task automatic checkStore(wordT gotAddr, wordT gotData, wordT expAddr, wordT expData);
		if (gotAddr !== expAddr || gotData !== expData) begin
			failRun($sformatf("** Error at %0t: store [%08h] = %08h, expected [%08h] = %08h",
				$time, gotAddr, gotData, expAddr, expData));
		end
	endtask

	// Outputs are sampled mid-cycle, away from the edge
	always @(negedge clk) begin
		if (checking && wbValid) begin
			if (wbReg == '0) begin
				failRun($sformatf("Register 0 was reported as written at time %0t", $time));
			end else if (expWbReg.size() == 0) begin
				failRun($sformatf("Register r%0d was written at time %0t, but no write was left",
					wbReg, $time));
			end else begin
				checkWriteback(wbReg, wbData, expWbReg.pop_front(), expWbData.pop_front());
			end
		end
	end

	always @(negedge clk) begin
		if (checking && memWrEn) begin
			if (expStAddr.size() == 0) begin
				failRun($sformatf("A store to %08h came at time %0t, but no store was left",
					memAddr, $time));
			end else begin
				checkStore(memAddr, memData, expStAddr.pop_front(), expStData.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	// Reset overlaps the load, so the PC cannot run ahead of it
	task automatic resetAndLoad();
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			if (i == RESET_CYCLES) rst = 1'b0;
			imemWrEn = 1'b1;
			imemAddr = IMEM_AW'(i);
			imemData = progMem[i];
			@(posedge clk);
			#1;
		end
		imemWrEn = 1'b0;                                // Fetch starts at PC 0 next edge
		imemAddr = '0;
		imemData = '0;
	endtask

	task automatic waitProgramDone();
		while (expWbReg.size() != 0 || expStAddr.size() != 0) begin
			@(negedge clk);
		end
		repeat (DRAIN_CYCLES) @(negedge clk);
	endtask

	initial begin
		int seedInit;
		rst        = 1'b1;
		imemWrEn   = 1'b0;
		imemAddr   = '0;
		imemData   = '0;
		checking   = 1'b0;
		seedInit   = $urandom(SEED);
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			genProgram();
			runModel();                                 // Fills the expected queues
			resetAndLoad();
			checking = 1'b1;
			waitProgramDone();
		end
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		failRun("Watchdog timeout: the programs did not retire in the expected time");
	end

endmodule

/* verilog/mipsCore.sv */
module mipsCore #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          imemWrEn_i,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imemAddr_i,
	input  mipsPkg::wordT                 imemData_i,
	output logic                          wbValid_o,     // Register write this cycle
	output mipsPkg::regAddrT              wbReg_o,
	output mipsPkg::wordT                 wbData_o,
	output logic                          memWrEn_o,     // Store this cycle
	output mipsPkg::wordT                 memAddr_o,
	output mipsPkg::wordT                 memData_o
);
	import mipsPkg::*;

	logic    stall;
	logic    flush;
	logic    branchTaken;
	wordT    branchTarget;
	wordT    ifPc4;                                     // IF/ID
	wordT    ifInstr;
	regAddrT decRs;
	regAddrT decRt;
	logic    decIsBranch;
	logic    wbRegWrite;                                // Writeback bus
	regAddrT wbDestReg;
	wordT    wbData;

	idExIf  idExBus ();
	exMemIf exMemBus ();

	////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////
	fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) uFetch (
		.clk(clk), .rst_i(rst_i), .stall_i(stall), .flush_i(flush),
		.branchTarget_i(branchTarget), .imemWrEn_i(imemWrEn_i), .imemAddr_i(imemAddr_i),
		.imemData_i(imemData_i), .ifPc4_o(ifPc4), .ifInstr_o(ifInstr)
	);

	decodeStage uDecode (
		.clk(clk), .rst_i(rst_i), .ifPc4_i(ifPc4), .ifInstr_i(ifInstr), .bubble_i(stall),
		.wbRegWrite_i(wbRegWrite), .wbDestReg_i(wbDestReg), .wbData_i(wbData),
		.idEx(idExBus.producer), .exMem(exMemBus.consumer), .branchTaken_o(branchTaken),
		.branchTarget_o(branchTarget), .rs_o(decRs), .rt_o(decRt), .isBranch_o(decIsBranch)
	);

	hazardUnit uHazard (
		.rs_i(decRs), .rt_i(decRt), .isBranch_i(decIsBranch), .branchTaken_i(branchTaken),
		.idEx(idExBus.consumer), .exMem(exMemBus.consumer), .stall_o(stall), .flush_o(flush)
	);

	executeStage uExecute (
		.clk(clk), .rst_i(rst_i), .idEx(idExBus.consumer), .exMem(exMemBus.producer),
		.wbRegWrite_i(wbRegWrite), .wbDestReg_i(wbDestReg), .wbData_i(wbData)
	);

	memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) uMemory (
		.clk(clk), .rst_i(rst_i), .exMem(exMemBus.consumer), .wbRegWrite_o(wbRegWrite),
		.wbDestReg_o(wbDestReg), .wbData_o(wbData), .memWrEn_o(memWrEn_o),
		.memAddr_o(memAddr_o), .memData_o(memData_o)
	);

	assign wbValid_o = wbRegWrite;
	assign wbReg_o   = wbDestReg;
	assign wbData_o  = wbData;

endmodule

/* verilog/memoryStage.sv */
module memoryStage #(
	parameter int DMEM_DEPTH = 64
) (
	input  logic             clk,
	input  logic             rst_i,
	exMemIf.consumer         exMem,
	output logic             wbRegWrite_o,
	output mipsPkg::regAddrT wbDestReg_o,
	output mipsPkg::wordT    wbData_o,
	output logic             memWrEn_o,         // One pulse per store
	output mipsPkg::wordT    memAddr_o,
	output mipsPkg::wordT    memData_o
);
	import mipsPkg::*;

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	wordT             dmem [DMEM_DEPTH];
	logic [IDX_W-1:0] wordIdx;
	wordT             loadWord;
	logic             mwRegWrite;               // MEM/WB register
	logic             mwMemToReg;
	regAddrT          mwDestReg;
	wordT             mwLoad;
	wordT             mwAlu;

	assign wordIdx  = exMem.aluResult[IDX_W+1:2];  // Byte address over 4, wraps at depth
	assign loadWord = dmem[wordIdx];               // Combinational read

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.memWrite) begin
			dmem[wordIdx] <= exMem.storeData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mwRegWrite <= 1'b0;
			mwMemToReg <= 1'b0;
			mwDestReg  <= '0;
			mwLoad     <= '0;
			mwAlu      <= '0;
		end else begin
			mwRegWrite <= exMem.regWrite;
			mwMemToReg <= exMem.memToReg;
			mwDestReg  <= exMem.destReg;
			mwLoad     <= loadWord;
			mwAlu      <= exMem.aluResult;
		end
	end

	// Writeback select
	assign wbData_o     = mwMemToReg ? mwLoad : mwAlu;
	assign wbDestReg_o  = mwDestReg;
	assign wbRegWrite_o = mwRegWrite && (mwDestReg != '0);  // r0 writes are dropped

	assign memWrEn_o = exMem.memWrite;
	assign memAddr_o = exMem.aluResult;
	assign memData_o = exMem.storeData;

endmodule

/* verilog/executeStage.sv */
module executeStage (
	input  logic             clk,
	input  logic             rst_i,
	idExIf.consumer          idEx,
	exMemIf.producer         exMem,
	input  logic             wbRegWrite_i,      // Writeback bus for forwarding
	input  mipsPkg::regAddrT wbDestReg_i,
	input  mipsPkg::wordT    wbData_i
);
	import mipsPkg::*;

	fwdSelT  selA;
	fwdSelT  selB;
	wordT    opA;
	wordT    opB;                              // Forwarded rt, also store data
	wordT    aluB;
	aluOpT   aluOp;
	wordT    aluResult;
	regAddrT destReg;

	// EX/MEM takes priority as the younger result
	function automatic fwdSelT pickSrc(regAddrT src, logic exWr, regAddrT exDst, logic wbWr,
		regAddrT wbDst);
		if (src == '0) return FWD_REG;             // r0 always reads zero
		if (exWr && exDst == src) return FWD_EXMEM;
		if (wbWr && wbDst == src) return FWD_MEMWB;
		return FWD_REG;
	endfunction

	function automatic wordT muxOperand(fwdSelT sel, wordT regVal, wordT exVal, wordT wbVal);
		case (sel)
			FWD_EXMEM: return exVal;
			FWD_MEMWB: return wbVal;
			default:   return regVal;
		endcase
	endfunction

	////////////////////////////////////////
	// Operand forwarding
	////////////////////////////////////////
	always_comb begin
		selA = pickSrc(idEx.rs, exMem.regWrite, exMem.destReg, wbRegWrite_i, wbDestReg_i);
		selB = pickSrc(idEx.rt, exMem.regWrite, exMem.destReg, wbRegWrite_i, wbDestReg_i);
		opA  = muxOperand(selA, idEx.rd1, exMem.aluResult, wbData_i);
		opB  = muxOperand(selB, idEx.rd2, exMem.aluResult, wbData_i);
	end

	assign aluB    = idEx.ctrl.aluSrc ? idEx.immediate : opB;
	assign destReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;  // rd for R-type, rt otherwise

	// ALU control
	always_comb begin
		aluOp = idEx.ctrl.aluOp;
		if (idEx.ctrl.aluOp == ALU_FUNCT) begin
			case (idEx.funct)
				FN_SUB:  aluOp = ALU_SUB;
				FN_AND:  aluOp = ALU_AND;
				FN_OR:   aluOp = ALU_OR;
				FN_SLT:  aluOp = ALU_SLT;
				default: aluOp = ALU_ADD;          // add and the all-zero NOP
			endcase
		end
	end

	always_comb begin
		case (aluOp)
			ALU_SUB: aluResult = opA - aluB;
			ALU_AND: aluResult = opA & aluB;
			ALU_OR:  aluResult = opA | aluB;
			ALU_SLT: aluResult = {{(DATA_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: aluResult = opA + aluB;       // add, addi, address calc
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			exMem.regWrite  <= 1'b0;
			exMem.memToReg  <= 1'b0;
			exMem.memWrite  <= 1'b0;
			exMem.memRead   <= 1'b0;
			exMem.aluResult <= '0;
			exMem.storeData <= '0;
			exMem.destReg   <= '0;
		end else begin
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memToReg  <= idEx.ctrl.memToReg;
			exMem.memWrite  <= idEx.ctrl.memWrite;
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.aluResult <= aluResult;
			exMem.storeData <= opB;
			exMem.destReg   <= destReg;
		end
	end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
	input  mipsPkg::regAddrT rs_i,              // Sources of the decode instruction
	input  mipsPkg::regAddrT rt_i,
	input  logic             isBranch_i,
	input  logic             branchTaken_i,
	idExIf.consumer          idEx,
	exMemIf.consumer         exMem,
	output logic             stall_o,
	output logic             flush_o
);
	import mipsPkg::*;

	regAddrT exDest;
	logic    loadUse;
	logic    branchExHit;
	logic    branchMemHit;

	// Decode reads this register, r0 excluded
	function automatic logic readsReg(regAddrT r, regAddrT srcA, regAddrT srcB);
		return (r != '0) && (r == srcA || r == srcB);
	endfunction

	assign exDest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;  // Destination of the EX instruction

	// Load result not ready before the next instruction reaches EX
	assign loadUse = idEx.ctrl.memRead && readsReg(idEx.rt, rs_i, rt_i);

	// Branch compares in decode, so wait for the producer to leave EX
	assign branchExHit  = isBranch_i && idEx.ctrl.regWrite && readsReg(exDest, rs_i, rt_i);
	assign branchMemHit = isBranch_i && exMem.memRead && readsReg(exMem.destReg, rs_i, rt_i);

	assign stall_o = loadUse | branchExHit | branchMemHit;
	assign flush_o = branchTaken_i && !stall_o;  // Squash the word fetched behind the branch

endmodule

/* verilog/decodeStage.sv */
module decodeStage (
	input  logic             clk,
	input  logic             rst_i,
	input  mipsPkg::wordT    ifPc4_i,
	input  mipsPkg::wordT    ifInstr_i,
	input  logic             bubble_i,          // Stall from hazard unit
	input  logic             wbRegWrite_i,
	input  mipsPkg::regAddrT wbDestReg_i,
	input  mipsPkg::wordT    wbData_i,
	idExIf.producer          idEx,
	exMemIf.consumer         exMem,             // ALU result for branch compare
	output logic             branchTaken_o,
	output mipsPkg::wordT    branchTarget_o,
	output mipsPkg::regAddrT rs_o,
	output mipsPkg::regAddrT rt_o,
	output logic             isBranch_o
);
	import mipsPkg::*;

	opcodeT opcode;
	ctrlT   ctrl;
	logic   isBeq;
	logic   isBne;
	wordT   regFile [REG_COUNT];
	wordT   rd1;
	wordT   rd2;
	wordT   immExt;
	wordT   cmpA;
	wordT   cmpB;
	logic   operandsEqual;

	// Register read with same-cycle writeback bypass
	function automatic wordT readReg(regAddrT addr);
		wordT value;
		value = regFile[addr];
		if (wbRegWrite_i && addr != '0 && wbDestReg_i == addr) begin
			value = wbData_i;
		end
		return value;
	endfunction

	assign opcode = opcodeT'(ifInstr_i[31:26]);
	assign rs_o   = ifInstr_i[25:21];
	assign rt_o   = ifInstr_i[20:16];
	assign immExt = {{16{ifInstr_i[15]}}, ifInstr_i[15:0]};  // Sign extend for every I-type

	////////////////////////////////////////
	// Control decoder
	////////////////////////////////////////
	always_comb begin
		ctrl  = '0;
		isBeq = 1'b0;
		isBne = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				ctrl.aluOp    = ALU_FUNCT;                // ALU control looks at funct
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_ADD;
			end
			OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.aluSrc   = 1'b1;                     // Address is base + offset
			end
			OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			OP_BEQ: isBeq = 1'b1;                         // Resolved here, no EX work
			OP_BNE: isBne = 1'b1;
			default: ctrl = '0;                           // Unknown opcode acts as NOP
		endcase
	end

	// Register file, r0 never written
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbRegWrite_i && wbDestReg_i != '0) begin
			regFile[wbDestReg_i] <= wbData_i;
		end
	end

	always_comb begin
		rd1 = readReg(rs_o);
		rd2 = readReg(rt_o);
	end

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////
	// A load in MEM stalls the branch, so only ALU results get here
	assign cmpA = (exMem.regWrite && exMem.destReg != '0 && exMem.destReg == rs_o) ?
		exMem.aluResult : rd1;
	assign cmpB = (exMem.regWrite && exMem.destReg != '0 && exMem.destReg == rt_o) ?
		exMem.aluResult : rd2;
	assign operandsEqual  = (cmpA == cmpB);
	assign isBranch_o     = isBeq | isBne;
	assign branchTaken_o  = ((isBeq && operandsEqual) || (isBne && !operandsEqual)) && !bubble_i;
	assign branchTarget_o = ifPc4_i + (immExt << 2);  // PC+4 relative, word offset

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			idEx.ctrl      <= '0;
			idEx.rd1       <= '0;
			idEx.rd2       <= '0;
			idEx.immediate <= '0;
			idEx.rs        <= '0;
			idEx.rt        <= '0;
			idEx.rd        <= '0;
			idEx.funct     <= FN_ADD;
		end else begin
			idEx.ctrl      <= bubble_i ? ctrlT'('0) : ctrl;  // Bubble kills writes only
			idEx.rd1       <= rd1;
			idEx.rd2       <= rd2;
			idEx.immediate <= immExt;
			idEx.rs        <= rs_o;
			idEx.rt        <= rt_o;
			idEx.rd        <= ifInstr_i[15:11];
			idEx.funct     <= functT'(ifInstr_i[5:0]);
		end
	end

endmodule

/* verilog/fetchStage.sv */
module fetchStage #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          stall_i,         // Hold PC and IF/ID
	input  logic                          flush_i,         // Taken branch in decode
	input  mipsPkg::wordT                 branchTarget_i,
	input  logic                          imemWrEn_i,      // Program load
	input  logic [$clog2(IMEM_DEPTH)-1:0] imemAddr_i,
	input  mipsPkg::wordT                 imemData_i,
	output mipsPkg::wordT                 ifPc4_o,
	output mipsPkg::wordT                 ifInstr_o
);
	import mipsPkg::*;

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	wordT pc;
	wordT pc4;
	wordT fetched;
	wordT imem [IMEM_DEPTH];                            // Instruction array

	assign pc4     = pc + 32'd4;
	assign fetched = imem[pc[IDX_W+1:2]];               // Word index, wraps at depth

	always_ff @(posedge clk) begin
		if (imemWrEn_i) begin
			imem[imemAddr_i] <= imemData_i;             // Load port
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc <= '0;
		end else if (!imemWrEn_i && !stall_i) begin
			pc <= flush_i ? branchTarget_i : pc4;       // Redirect or sequential
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ifPc4_o   <= '0;
			ifInstr_o <= NOP_WORD;
		end else if (imemWrEn_i) begin
			ifInstr_o <= NOP_WORD;                      // Nothing issues while loading
		end else if (!stall_i) begin
			ifPc4_o   <= pc4;
			ifInstr_o <= flush_i ? NOP_WORD : fetched;  // Squash wrong-path word
		end
	end

endmodule

/* verilog/pipeIf.sv */
// ID/EX pipeline register contents
interface idExIf;
	import mipsPkg::*;

	ctrlT    ctrl;          // Zeroed for a bubble
	wordT    rd1;           // rs value from decode
	wordT    rd2;           // rt value from decode
	wordT    immediate;     // Sign-extended imm16
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	functT   funct;         // R-type function field

	modport producer (output ctrl, rd1, rd2, immediate, rs, rt, rd, funct);
	modport consumer (input ctrl, rd1, rd2, immediate, rs, rt, rd, funct);
endinterface

// EX/MEM pipeline register contents
interface exMemIf;
	import mipsPkg::*;

	logic    regWrite;
	logic    memToReg;
	logic    memWrite;
	logic    memRead;
	wordT    aluResult;     // Result or memory byte address
	wordT    storeData;     // Forwarded rt for sw
	regAddrT destReg;

	modport producer (output regWrite, memToReg, memWrite, memRead, aluResult, storeData,
		destReg);
	modport consumer (input regWrite, memToReg, memWrite, memRead, aluResult, storeData,
		destReg);
endinterface

/* verilog/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////
	// Widths and basic types
	////////////////////////////////////////
	localparam int DATA_W     = 32;                 // Machine word
	localparam int REG_ADDR_W = 5;                  // Register index
	localparam int REG_COUNT  = 2 ** REG_ADDR_W;    // Entries in the register file

	typedef logic [DATA_W-1:0]     wordT;           // Data or instruction word
	typedef logic [REG_ADDR_W-1:0] regAddrT;        // Register index

	localparam wordT NOP_WORD = '0;                 // sll $0,$0,0 used as squash filler

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} functT;

	// Class from the decoder, final operation after ALU control
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_SLT   = 3'd4,
		ALU_FUNCT = 3'd7                            // R-type, operation from funct
	} aluOpT;

	////////////////////////////////////////
	// Pipeline control
	////////////////////////////////////////
	typedef struct packed {
		logic  regWrite;                            // Writes a register in WB
		logic  memToReg;                            // WB data from memory
		logic  memWrite;                            // Store
		logic  memRead;                             // Load
		logic  regDst;                              // Destination rd, else rt
		logic  aluSrc;                              // Second operand immediate
		aluOpT aluOp;                               // Operation class
	} ctrlT;

	typedef enum logic [1:0] {
		FWD_REG   = 2'b00,                          // Value read in decode
		FWD_MEMWB = 2'b01,                          // Writeback data
		FWD_EXMEM = 2'b10                           // ALU result one stage ahead
	} fwdSelT;

endpackage
